/* Makefile */
TOOL    = verilator
FLAGS   = --binary --timing --assert -j 0
TOP     = tb_mem_wb_top
FLIST   = mem_wb_top.f
OBJ_DIR = obj_dir
LOG     = sim.log
PASS    = All checks passed

SRCS = $(shell grep -v '^+' $(FLIST))
BIN  = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# the simulator output is kept in the log and searched for the pass line
run: compile
	-./$(BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_mem_wb_top.sv */
`timescale 1ns/1ps

`include "wb_macros.svh"

module tb_mem_wb_top;

   // ################################################
   // test sizes and run limit
   // ################################################

   localparam int N_SEL_LEGAL = 7;    // codes 0 to 6
   localparam int N_MEM       = 12;
   localparam int N_PAIR      = 6;
   localparam int STALL_CYC   = 4;

   localparam int RESET_LEN   = 2 + 1 + `WB_REG_CNT;
   localparam int SELECT_LEN  = N_SEL_LEGAL * 3;
   localparam int MEM_LEN     = N_MEM + N_MEM * 3 + N_PAIR * 4;
   localparam int STALL_LEN   = 1 + STALL_CYC + 3 + 3;
   localparam int ILLEGAL_LEN = 3;
   localparam int DUAL_LEN    = `WB_REG_CNT + 1;
   localparam int TEST_CYCLES = RESET_LEN + SELECT_LEN + MEM_LEN + STALL_LEN
                                + ILLEGAL_LEN + DUAL_LEN;
   localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

   logic                 clk = 1'b0;
   logic                 arst_n;
   logic                 stall_n;
   wb_pkg::ex_mem_s      ex_mem;
   wb_pkg::wb_reg_idx_t  rd_addr_a;
   wb_pkg::wb_reg_idx_t  rd_addr_b;
   wb_pkg::wb_data_t     rd_data_a;
   wb_pkg::wb_data_t     rd_data_b;
   wb_pkg::rf_write_s    wb_write;
   logic                 err;

   // reference models
   wb_pkg::wb_data_t     reg_model [`WB_REG_CNT];
   wb_pkg::wb_data_t     mem_model [`WB_MEM_DEPTH];
   wb_pkg::wb_data_t     mem_out_model;

   logic [31:0]          rng = 32'hc988;
   int                   cycle_cnt = 0;
   string                test_name = "start";

   mem_wb_top u_dut (
      .clk       (clk),
      .arst_n    (arst_n),
      .stall_n   (stall_n),
      .ex_mem    (ex_mem),
      .rd_addr_a (rd_addr_a),
      .rd_addr_b (rd_addr_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .wb_write  (wb_write),
      .err       (err)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: run went past %0d cycles without finishing", TIMEOUT_CYCLES);
         abort_run();
      end
   end

   // ################################################
   // helpers
   // ################################################

   task automatic abort_run();
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_word(input string what, input wb_pkg::wb_data_t exp,
                             input wb_pkg::wb_data_t act);
      assert (act === exp) else begin
         $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
         abort_run();
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      assert (act === exp) else begin
         $display("Fail %s %s: expected %b, actual %b", test_name, what, exp, act);
         abort_run();
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic wb_pkg::wb_data_t rand_word();
      rng = xorshift32(rng);
      return rng[15:0];
   endfunction

   function automatic wb_pkg::wb_reg_idx_t rand_idx();
      wb_pkg::wb_data_t w;
      w = rand_word();
      return w[2:0];
   endfunction

   function automatic wb_pkg::ex_mem_s random_bundle(input wb_pkg::wb_sel_t sel,
                                                     input wb_pkg::wb_reg_idx_t idx);
      wb_pkg::ex_mem_s  b;
      wb_pkg::wb_data_t w;
      b            = '0;
      b.wr_en      = 1'b1;
      b.wr_reg     = idx;
      b.wr_sel     = sel;
      b.alu_out    = rand_word();
      b.store_data = rand_word();
      b.pc_inc     = rand_word();
      b.lbi        = rand_word();
      b.slbi       = rand_word();
      b.sext_imm   = rand_word();
      w            = rand_word();
      b.set        = w[0];
      return b;
   endfunction

   // store only, no register write
   function automatic wb_pkg::ex_mem_s store_bundle(input wb_pkg::wb_data_t addr);
      wb_pkg::ex_mem_s b;
      b         = random_bundle(wb_pkg::SEL_ALU, 3'd0);
      b.wr_en   = 1'b0;
      b.mem_wr  = 1'b1;
      b.alu_out = addr;
      return b;
   endfunction

   function automatic wb_pkg::ex_mem_s load_bundle(input wb_pkg::wb_data_t addr,
                                                   input wb_pkg::wb_reg_idx_t idx);
      wb_pkg::ex_mem_s b;
      b         = random_bundle(wb_pkg::SEL_MEM, idx);
      b.mem_rd  = 1'b1;
      b.alu_out = addr;
      return b;
   endfunction

   // writeback source rule
   function automatic wb_pkg::wb_data_t select_source(input wb_pkg::ex_mem_s b,
                                                      input wb_pkg::wb_data_t mem_word);
      case (b.wr_sel)
         wb_pkg::SEL_ALU:      return b.alu_out;
         wb_pkg::SEL_MEM:      return mem_word;
         wb_pkg::SEL_PC_INC:   return b.pc_inc;
         wb_pkg::SEL_LBI:      return b.lbi;
         wb_pkg::SEL_SLBI:     return b.slbi;
         wb_pkg::SEL_SEXT_IMM: return b.sext_imm;
         wb_pkg::SEL_SET:      return {{(`WB_DATA_W-1){1'b0}}, b.set};
         default:              return '0;
      endcase
   endfunction

   // memory side effect of a bundle accepted with stall_n high
   function automatic void apply_mem(input wb_pkg::ex_mem_s b);
      wb_pkg::wb_mem_addr_t a;
      a = b.alu_out[`WB_MEM_AW:1];
      if (b.mem_wr) begin
         mem_model[a] = b.store_data;
      end
      if (b.mem_rd) begin
         mem_out_model = mem_model[a];
      end
   endfunction

   task automatic issue(input wb_pkg::ex_mem_s b);
      @(posedge clk);
      ex_mem <= b;
      apply_mem(b);
   endtask

   // bundle in N, bypass read in N+1, array read in N+2
   task automatic write_and_check(input wb_pkg::ex_mem_s b);
      wb_pkg::wb_data_t    exp;
      wb_pkg::wb_reg_idx_t other;
      other = b.wr_reg + 3'd1;
      @(posedge clk);
      ex_mem    <= b;
      rd_addr_a <= b.wr_reg;
      rd_addr_b <= other;
      apply_mem(b);
      exp = select_source(b, mem_out_model);
      @(posedge clk);
      ex_mem <= '0;
      @(negedge clk);
      check_bit("wb_write.en", 1'b1, wb_write.en);
      check_word("wb_write.idx", wb_pkg::wb_data_t'(b.wr_reg),
                 wb_pkg::wb_data_t'(wb_write.idx));
      check_word("wb_write.data", exp, wb_write.data);
      check_word("bypass read", exp, rd_data_a);
      check_word("other port", reg_model[other], rd_data_b);
      reg_model[b.wr_reg] = exp;
      @(negedge clk);
      check_bit("idle wb_write.en", 1'b0, wb_write.en);
      check_word("array read", exp, rd_data_a);
   endtask

   // ################################################
   // tests
   // ################################################

   task automatic test_reset();
      test_name = "reset";
      @(negedge clk);
      check_bit("wb_write.en", 1'b0, wb_write.en);
      check_bit("err", 1'b0, err);
      for (int i = 0; i < `WB_REG_CNT; i++) begin
         @(posedge clk);
         rd_addr_a <= wb_pkg::wb_reg_idx_t'(i);
         rd_addr_b <= wb_pkg::wb_reg_idx_t'(`WB_REG_CNT - 1 - i);
         @(negedge clk);
         check_word("rd_data_a", '0, rd_data_a);
         check_word("rd_data_b", '0, rd_data_b);
      end
   endtask

   task automatic test_select();
      wb_pkg::ex_mem_s b;
      test_name = "source select";
      for (int s = 0; s < N_SEL_LEGAL; s++) begin
         b = random_bundle(wb_pkg::wb_sel_t'(s), rand_idx());
         write_and_check(b);   // SEL_MEM sees the held mem_out
      end
   endtask

   task automatic test_store_load();
      wb_pkg::ex_mem_s  b;
      wb_pkg::wb_data_t w;
      wb_pkg::wb_data_t addrs [N_MEM];
      test_name = "store load";
      for (int i = 0; i < N_MEM; i++) begin
         addrs[i] = rand_word();
         issue(store_bundle(addrs[i]));
      end
      for (int i = 0; i < N_MEM; i++) begin
         b = load_bundle(addrs[i], rand_idx());
         write_and_check(b);
      end
      // load right behind the store
      for (int i = 0; i < N_PAIR; i++) begin
         w = rand_word();
         issue(store_bundle(w));
         write_and_check(load_bundle(w, rand_idx()));
      end
   endtask

   task automatic test_stall();
      wb_pkg::ex_mem_s  b;
      wb_pkg::wb_data_t old;
      test_name = "stall";
      b        = random_bundle(wb_pkg::SEL_ALU, rand_idx());
      b.mem_wr = 1'b1;
      old      = reg_model[b.wr_reg];
      @(posedge clk);
      ex_mem    <= b;
      stall_n   <= 1'b0;
      rd_addr_a <= b.wr_reg;
      repeat (STALL_CYC) begin
         @(posedge clk);
         @(negedge clk);
         check_bit("wb_write.en under stall", 1'b0, wb_write.en);
         check_word("held register", old, rd_data_a);
      end
      @(posedge clk);
      stall_n <= 1'b1;
      apply_mem(b);
      @(negedge clk);
      check_bit("wb_write.en after stall", 1'b0, wb_write.en);
      @(posedge clk);
      ex_mem <= '0;
      @(negedge clk);
      check_bit("released wb_write.en", 1'b1, wb_write.en);
      check_word("released write", b.alu_out, rd_data_a);
      reg_model[b.wr_reg] = b.alu_out;
      @(negedge clk);
      check_bit("single write", 1'b0, wb_write.en);
      check_word("array read", b.alu_out, rd_data_a);
      write_and_check(load_bundle(b.alu_out, rand_idx()));   // store landed
   endtask

   task automatic test_illegal_select();
      wb_pkg::ex_mem_s b;
      test_name = "illegal select";
      b = random_bundle(wb_pkg::wb_sel_t'(7), rand_idx());
      @(posedge clk);
      ex_mem    <= b;
      rd_addr_a <= b.wr_reg;
      @(posedge clk);
      ex_mem <= '0;
      @(negedge clk);
      check_bit("err", 1'b1, err);
      check_bit("wb_write.en", 1'b0, wb_write.en);
      check_word("no bypass", reg_model[b.wr_reg], rd_data_a);
      @(negedge clk);
      check_bit("err after", 1'b0, err);
      check_word("kept register", reg_model[b.wr_reg], rd_data_a);
   endtask

   // port a on the register in writeback, port b elsewhere
   task automatic test_dual_read();
      wb_pkg::ex_mem_s     b;
      wb_pkg::ex_mem_s     prev;
      wb_pkg::wb_reg_idx_t ia;
      wb_pkg::wb_reg_idx_t ib;
      test_name = "dual read";
      prev = '0;
      for (int k = 0; k <= `WB_REG_CNT; k++) begin
         b = '0;
         if (k < `WB_REG_CNT) begin
            b = random_bundle(wb_pkg::SEL_ALU, wb_pkg::wb_reg_idx_t'(k));
         end
         ia = wb_pkg::wb_reg_idx_t'(k - 1);
         ib = wb_pkg::wb_reg_idx_t'(k + 2);
         @(posedge clk);
         ex_mem    <= b;
         rd_addr_a <= ia;
         rd_addr_b <= ib;
         if (prev.wr_en) begin
            reg_model[prev.wr_reg] = prev.alu_out;
         end
         @(negedge clk);
         check_word("port a", reg_model[ia], rd_data_a);
         check_word("port b", reg_model[ib], rd_data_b);
         prev = b;
      end
   endtask

   // ################################################
   // run
   // ################################################

   initial begin
      arst_n        = 1'b0;
      stall_n       = 1'b1;
      ex_mem        = '0;
      rd_addr_a     = '0;
      rd_addr_b     = '0;
      mem_out_model = '0;
      for (int i = 0; i < `WB_REG_CNT; i++) begin
         reg_model[i] = '0;
      end
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;
      test_reset();
      test_select();
      test_store_load();
      test_stall();
      test_illegal_select();
      test_dual_read();
      $display("All checks passed");
      $finish;
   end

endmodule

/* logic/data_mem.sv */
`timescale 1ns/1ps

`include "wb_macros.svh"

module data_mem (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              stall_n,    // low holds the stage
   input  wb_pkg::ex_mem_s   ex_mem,
   output wb_pkg::wb_data_t  mem_out
);

   // ################################################
   // storage
   // ################################################

   wb_pkg::wb_data_t     mem [`WB_MEM_DEPTH];
   wb_pkg::wb_mem_addr_t addr;
   logic                 wr_go;
   logic                 rd_go;

   // word aligned, bit 0 dropped
   assign addr  = ex_mem.alu_out[`WB_MEM_AW:1];

   assign wr_go = ex_mem.mem_wr & stall_n;   // no store while held
   assign rd_go = ex_mem.mem_rd & stall_n;

   always_ff @(posedge clk) begin
      if (wr_go) begin
         mem[addr] <= ex_mem.store_data;
      end
   end

   // ################################################
   // registered read port
   // ################################################

   // old word on a same-edge store, new word from the next cycle on
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mem_out <= '0;
      end else if (rd_go) begin
         mem_out <= mem[addr];
      end
   end

   // ################################################
   // checks
   // ################################################

   // one memory op per instruction
   a_no_rd_and_wr : assert property (
      @(posedge clk) disable iff (!arst_n)
      !(ex_mem.mem_rd && ex_mem.mem_wr)
   ) else $error("data_mem: mem_rd and mem_wr both set");

endmodule

/* logic/mem_wb.sv */
`timescale 1ns/1ps

module mem_wb (
   input  logic             clk,
   input  logic             arst_n,
   input  logic             stall_n,
   input  wb_pkg::ex_mem_s  ex_mem,
   output wb_pkg::mem_wb_s  wb
);

   // ################################################
   // stage register
   // ################################################

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb <= '0;
      end else if (!stall_n) begin
         wb.wr_en <= 1'b0;   // bubble, data fields held
      end else begin
         wb.wr_en    <= ex_mem.wr_en;
         wb.wr_reg   <= ex_mem.wr_reg;
         wb.wr_sel   <= ex_mem.wr_sel;
         wb.alu_out  <= ex_mem.alu_out;
         wb.pc_inc   <= ex_mem.pc_inc;
         wb.lbi      <= ex_mem.lbi;
         wb.slbi     <= ex_mem.slbi;
         wb.sext_imm <= ex_mem.sext_imm;
         wb.set      <= ex_mem.set;
      end
   end

   // ################################################
   // checks
   // ################################################

   // producer holds the bundle until the stage is released
   a_bundle_held : assert property (
      @(posedge clk) disable iff (!arst_n)
      !stall_n |=> $stable(ex_mem)
   ) else $error("mem_wb: ex_mem changed during a stall");

endmodule

/* logic/mem_wb_top.sv */
`timescale 1ns/1ps

module mem_wb_top (
   input  logic                 clk,
   input  logic                 arst_n,
   input  logic                 stall_n,
   input  wb_pkg::ex_mem_s      ex_mem,
   input  wb_pkg::wb_reg_idx_t  rd_addr_a,
   input  wb_pkg::wb_reg_idx_t  rd_addr_b,
   output wb_pkg::wb_data_t     rd_data_a,
   output wb_pkg::wb_data_t     rd_data_b,
   output wb_pkg::rf_write_s    wb_write,
   output logic                 err
);

   wb_pkg::wb_data_t mem_out;
   wb_pkg::mem_wb_s  wb;

   // ################################################
   // memory stage, both paths one cycle
   // ################################################

   data_mem u_data_mem (
      .clk     (clk),
      .arst_n  (arst_n),
      .stall_n (stall_n),
      .ex_mem  (ex_mem),
      .mem_out (mem_out)
   );

   mem_wb u_mem_wb (
      .clk     (clk),
      .arst_n  (arst_n),
      .stall_n (stall_n),
      .ex_mem  (ex_mem),
      .wb      (wb)
   );

   // ################################################
   // writeback
   // ################################################

   wb_select u_wb_select (
      .wb       (wb),
      .mem_out  (mem_out),
      .rf_write (wb_write),
      .err      (err)
   );

   reg_file u_reg_file (
      .clk       (clk),
      .arst_n    (arst_n),
      .rf_write  (wb_write),
      .rd_addr_a (rd_addr_a),
      .rd_addr_b (rd_addr_b),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b)
   );

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps

`include "wb_macros.svh"

module reg_file (
   input  logic                 clk,
   input  logic                 arst_n,
   input  wb_pkg::rf_write_s    rf_write,
   input  wb_pkg::wb_reg_idx_t  rd_addr_a,
   input  wb_pkg::wb_reg_idx_t  rd_addr_b,
   output wb_pkg::wb_data_t     rd_data_a,
   output wb_pkg::wb_data_t     rd_data_b
);

   // ################################################
   // register array
   // ################################################

   wb_pkg::wb_data_t regs [`WB_REG_CNT];
   logic             hit_a;
   logic             hit_b;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `WB_REG_CNT; i++) begin
            regs[i] <= '0;
         end
      end else if (rf_write.en) begin
         regs[rf_write.idx] <= rf_write.data;
      end
   end

   // ################################################
   // read ports with write bypass
   // ################################################

   // same-cycle write wins over the array
   assign hit_a = rf_write.en & (rf_write.idx == rd_addr_a);
   assign hit_b = rf_write.en & (rf_write.idx == rd_addr_b);

   assign rd_data_a = hit_a ? rf_write.data : regs[rd_addr_a];
   assign rd_data_b = hit_b ? rf_write.data : regs[rd_addr_b];

   // ################################################
   // checks
   // ################################################

   // an X here would corrupt the array and any bypassed read
   a_wr_data_known : assert property (
      @(posedge clk) disable iff (!arst_n)
      rf_write.en |-> !$isunknown(rf_write.data)
   ) else $error("reg_file: unknown write data on enabled write");

endmodule

/* logic/wb_macros.svh */
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

// ################################################
// data path
// ################################################
`define WB_DATA_W     16
`define WB_SEL_W      3

// ################################################
// storage sizes
// ################################################
`define WB_REG_AW     3
`define WB_REG_CNT    8
`define WB_MEM_AW     8     // word address, alu_out[8:1]
`define WB_MEM_DEPTH  256

`endif

/* logic/wb_pkg.sv */
`include "wb_macros.svh"

package wb_pkg;

   typedef logic [`WB_DATA_W-1:0] wb_data_t;
   typedef logic [`WB_REG_AW-1:0] wb_reg_idx_t;
   typedef logic [`WB_SEL_W-1:0]  wb_sel_t;
   typedef logic [`WB_MEM_AW-1:0] wb_mem_addr_t;

   // writeback source codes
   localparam wb_sel_t SEL_ALU      = 3'd0;
   localparam wb_sel_t SEL_MEM      = 3'd1;
   localparam wb_sel_t SEL_PC_INC   = 3'd2;
   localparam wb_sel_t SEL_LBI      = 3'd3;
   localparam wb_sel_t SEL_SLBI     = 3'd4;
   localparam wb_sel_t SEL_SEXT_IMM = 3'd5;
   localparam wb_sel_t SEL_SET      = 3'd6;
   localparam wb_sel_t SEL_BAD      = 3'd7;   // never legal

   typedef struct packed {
      logic        wr_en;
      wb_reg_idx_t wr_reg;
      wb_sel_t     wr_sel;
      logic        mem_rd;
      logic        mem_wr;
      wb_data_t    alu_out;     // also the memory address
      wb_data_t    store_data;
      wb_data_t    pc_inc;
      wb_data_t    lbi;
      wb_data_t    slbi;
      wb_data_t    sext_imm;
      logic        set;
   } ex_mem_s;

   typedef struct packed {
      logic        wr_en;
      wb_reg_idx_t wr_reg;
      wb_sel_t     wr_sel;
      wb_data_t    alu_out;
      wb_data_t    pc_inc;
      wb_data_t    lbi;
      wb_data_t    slbi;
      wb_data_t    sext_imm;
      logic        set;
   } mem_wb_s;

   typedef struct packed {
      logic        en;
      wb_reg_idx_t idx;
      wb_data_t    data;
   } rf_write_s;

endpackage

/* logic/wb_select.sv */
`timescale 1ns/1ps

module wb_select (
   input  wb_pkg::mem_wb_s    wb,
   input  wb_pkg::wb_data_t   mem_out,
   output wb_pkg::rf_write_s  rf_write,
   output logic               err
);

   wb_pkg::wb_data_t wr_data;

   // ################################################
   // result mux
   // ################################################

   always_comb begin
      case (wb.wr_sel)
         wb_pkg::SEL_ALU:      wr_data = wb.alu_out;
         wb_pkg::SEL_MEM:      wr_data = mem_out;     // loaded word
         wb_pkg::SEL_PC_INC:   wr_data = wb.pc_inc;   // link
         wb_pkg::SEL_LBI:      wr_data = wb.lbi;
         wb_pkg::SEL_SLBI:     wr_data = wb.slbi;
         wb_pkg::SEL_SEXT_IMM: wr_data = wb.sext_imm;
         wb_pkg::SEL_SET:      wr_data = wb_pkg::wb_data_t'(wb.set);
         default:              wr_data = '0;
      endcase
   end

   // only matters when something would be written
   assign err = wb.wr_en & (wb.wr_sel == wb_pkg::SEL_BAD);

   assign rf_write.en   = wb.wr_en & ~err;
   assign rf_write.idx  = wb.wr_reg;
   assign rf_write.data = wr_data;

endmodule

/* mem_wb_top.f */
+incdir+logic
logic/wb_pkg.sv
logic/data_mem.sv
logic/mem_wb.sv
logic/wb_select.sv
logic/reg_file.sv
logic/mem_wb_top.sv
bench/tb_mem_wb_top.sv
